// File: src/dps_pkg.sv
// Shared types and constants; bus addresses are byte addresses, the timer range ignores address bits 1:0
package dps_pkg;

	typedef logic [31:0] dps_addr_t;
	typedef logic [31:0] dps_data_t;
	typedef logic [4:0] dps_reg_idx_t;
	typedef logic [5:0] dps_irq_num_t;
	typedef logic [1:0] dps_irq_level_t;

	// Owner tracking for a pending read at the top level
	typedef enum logic {
		STAMP_IDLE,
		STAMP_READ_WAIT
	} dps_stamp_e;

	typedef enum logic [1:0] {
		SCI_TX_IDLE,
		SCI_TX_START,
		SCI_TX_DATA,
		SCI_TX_STOP
	} sci_tx_state_e;

	typedef enum logic [1:0] {
		SCI_RX_IDLE,
		SCI_RX_START,
		SCI_RX_DATA,
		SCI_RX_STOP
	} sci_rx_state_e;

	// Interrupt vector numbers
	localparam dps_irq_num_t IRQ_NUM_UTIM64 = 6'h36;
	localparam dps_irq_num_t IRQ_NUM_SCI = 6'h37;

	// Address decode
	localparam dps_addr_t UTIM64_LAST_ADDR = 32'h0000_0074;
	localparam dps_addr_t SCI_DATA_ADDR = 32'h0000_0100;
	localparam dps_addr_t SCI_STAT_ADDR = 32'h0000_0108;

	// Timer register word indices
	localparam dps_reg_idx_t UTIM64_CTRL_IDX = 5'd0;
	localparam dps_reg_idx_t UTIM64_COUNT_LO_IDX = 5'd1;
	localparam dps_reg_idx_t UTIM64_COUNT_HI_IDX = 5'd2;
	localparam dps_reg_idx_t UTIM64_CMP_LO_IDX = 5'd3;
	localparam dps_reg_idx_t UTIM64_CMP_HI_IDX = 5'd4;
	localparam dps_reg_idx_t UTIM64_PERIOD_IDX = 5'd5;

	// SCI register word indices
	localparam dps_reg_idx_t SCI_DATA_IDX = 5'd0;
	localparam dps_reg_idx_t SCI_STAT_IDX = 5'd2;

endpackage

// File: src/dps_req_if.sv
// Single-cycle request channel to one device; the host asserts req only while the device is not busy
`timescale 1ns/1ps

interface dps_req_if
	import dps_pkg::*;
();

	// Host to device
	logic req;
	logic rw;
	dps_reg_idx_t addr;
	dps_data_t wdata;

	// Device to host
	logic busy;
	logic rvalid;
	dps_data_t rdata;

	modport host (
		output req, rw, addr, wdata,
		input busy, rvalid, rdata
	);

	modport device (
		input req, rw, addr, wdata,
		output busy, rvalid, rdata
	);

endinterface

// File: src/dps_utim64.sv
// 64-bit timer ticking every TIMER_DIV clocks; count halves are written separately and are not read atomically
`timescale 1ns/1ps

module dps_utim64
	import dps_pkg::*;
#(
	parameter int TIMER_DIV = 4
) (
	input logic iCLOCK,
	input logic inRESET,
	dps_req_if.device bus,
	output logic irq,
	input logic irq_ack
);

	localparam int PW = (TIMER_DIV > 1) ? $clog2(TIMER_DIV) : 1;

	logic [PW-1:0] presc;
	logic tick;
	logic [2:0] ctrl;
	logic [63:0] count;
	logic [63:0] compare;
	dps_data_t period;
	logic match;
	logic match_q;
	logic hit;
	logic wr;
	logic rd;

	assign wr = bus.req && bus.rw;
	assign rd = bus.req && !bus.rw;
	assign tick = ctrl[0] && (presc == PW'(TIMER_DIV - 1));
	assign match = (count == compare);
	// Only the first cycle of an equal count counts as a hit
	assign hit = match && !match_q;
	assign bus.busy = bus.rvalid;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			presc <= '0;
		end else if (!ctrl[0] || tick) begin
			presc <= '0;
		end else begin
			presc <= presc + 1'b1;
		end
	end

	// Bus writes to the count override the increment
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			count <= '0;
		end else if (wr && bus.addr == UTIM64_COUNT_LO_IDX) begin
			count[31:0] <= bus.wdata;
		end else if (wr && bus.addr == UTIM64_COUNT_HI_IDX) begin
			count[63:32] <= bus.wdata;
		end else if (tick) begin
			count <= count + 64'd1;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			ctrl <= '0;
			compare <= '0;
			period <= '0;
			match_q <= 1'b1;
		end else begin
			match_q <= match;
			if (wr && bus.addr == UTIM64_CTRL_IDX) begin
				ctrl <= bus.wdata[2:0];
			end
			if (wr && bus.addr == UTIM64_PERIOD_IDX) begin
				period <= bus.wdata;
			end
			if (wr && bus.addr == UTIM64_CMP_LO_IDX) begin
				compare[31:0] <= bus.wdata;
			end else if (wr && bus.addr == UTIM64_CMP_HI_IDX) begin
				compare[63:32] <= bus.wdata;
			end else if (hit && ctrl[2]) begin
				// Periodic mode moves the next match forward
				compare <= compare + {32'd0, period};
			end
		end
	end

	// Compare flag, held until the controller acks it
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			irq <= 1'b0;
		end else if (hit && ctrl[1]) begin
			irq <= 1'b1;
		end else if (irq_ack) begin
			irq <= 1'b0;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			bus.rvalid <= 1'b0;
		end else begin
			bus.rvalid <= rd;
		end
	end

	always_ff @(posedge iCLOCK) begin
		case (bus.addr)
			UTIM64_CTRL_IDX: bus.rdata <= {29'd0, ctrl};
			UTIM64_COUNT_LO_IDX: bus.rdata <= count[31:0];
			UTIM64_COUNT_HI_IDX: bus.rdata <= count[63:32];
			UTIM64_CMP_LO_IDX: bus.rdata <= compare[31:0];
			UTIM64_CMP_HI_IDX: bus.rdata <= compare[63:32];
			UTIM64_PERIOD_IDX: bus.rdata <= period;
			default: bus.rdata <= '0;
		endcase
	end

	// Top-level gating keeps read requests from arriving back to back
	rvalid_single: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		bus.rvalid |=> !bus.rvalid);

endmodule

// File: src/dps_sci.sv
// 8N1 serial port at BAUD_DIV clocks per bit; one-byte receive holding register, no parity or flow control
`timescale 1ns/1ps

module dps_sci
	import dps_pkg::*;
#(
	parameter int BAUD_DIV = 8
) (
	input logic iCLOCK,
	input logic inRESET,
	dps_req_if.device bus,
	output logic txd,
	input logic rxd,
	output logic irq,
	input logic irq_ack
);

	localparam int CW = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
	localparam logic [CW-1:0] BIT_END = CW'(BAUD_DIV - 1);
	localparam logic [CW-1:0] HALF_BIT = CW'((BAUD_DIV > 1) ? BAUD_DIV / 2 - 1 : 0);

	logic wr;
	logic rd;
	logic [1:0] irq_en;
	sci_tx_state_e tx_state;
	logic [CW-1:0] tx_cnt;
	logic [2:0] tx_bit;
	logic [7:0] tx_shift;
	logic tx_start;
	logic tx_busy;
	logic tx_finish;
	logic rxd_meta;
	logic rxd_s;
	sci_rx_state_e rx_state;
	logic [CW-1:0] rx_cnt;
	logic [2:0] rx_bit;
	logic [7:0] rx_shift;
	logic [7:0] rx_data;
	logic rx_valid;
	logic rx_stop_ok;

	assign wr = bus.req && bus.rw;
	assign rd = bus.req && !bus.rw;
	assign tx_busy = (tx_state != SCI_TX_IDLE);
	assign tx_start = wr && bus.addr == SCI_DATA_IDX && !tx_busy;
	assign tx_finish = (tx_state == SCI_TX_STOP) && (tx_cnt == BIT_END);
	// Stop bit sampled high at mid-bit
	assign rx_stop_ok = (rx_state == SCI_RX_STOP) && (rx_cnt == BIT_END) && rxd_s;
	assign bus.busy = tx_busy || bus.rvalid;

	// Transmitter, LSB first
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			tx_state <= SCI_TX_IDLE;
			tx_cnt <= '0;
			tx_bit <= '0;
			txd <= 1'b1;
		end else begin
			tx_cnt <= (tx_cnt == BIT_END) ? '0 : tx_cnt + 1'b1;
			case (tx_state)
				SCI_TX_IDLE: begin
					tx_cnt <= '0;
					if (tx_start) begin
						tx_state <= SCI_TX_START;
						txd <= 1'b0;
					end
				end
				SCI_TX_START: begin
					if (tx_cnt == BIT_END) begin
						tx_state <= SCI_TX_DATA;
						tx_bit <= '0;
						txd <= tx_shift[0];
					end
				end
				SCI_TX_DATA: begin
					if (tx_cnt == BIT_END) begin
						tx_bit <= tx_bit + 1'b1;
						if (tx_bit == 3'd7) begin
							tx_state <= SCI_TX_STOP;
							txd <= 1'b1;
						end else begin
							txd <= tx_shift[1];
						end
					end
				end
				SCI_TX_STOP: begin
					if (tx_finish) begin
						tx_state <= SCI_TX_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (tx_start) begin
			tx_shift <= bus.wdata[7:0];
		end else if (tx_state == SCI_TX_DATA && tx_cnt == BIT_END) begin
			tx_shift <= tx_shift >> 1;
		end
	end

	// Receiver; start bit checked at half a bit, then every full bit
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			rxd_meta <= 1'b1;
			rxd_s <= 1'b1;
			rx_state <= SCI_RX_IDLE;
			rx_cnt <= '0;
			rx_bit <= '0;
		end else begin
			rxd_meta <= rxd;
			rxd_s <= rxd_meta;
			rx_cnt <= (rx_cnt == BIT_END) ? '0 : rx_cnt + 1'b1;
			case (rx_state)
				SCI_RX_IDLE: begin
					rx_cnt <= '0;
					if (!rxd_s) begin
						rx_state <= SCI_RX_START;
					end
				end
				SCI_RX_START: begin
					if (rx_cnt == HALF_BIT) begin
						rx_cnt <= '0;
						rx_bit <= '0;
						rx_state <= rxd_s ? SCI_RX_IDLE : SCI_RX_DATA;
					end
				end
				SCI_RX_DATA: begin
					if (rx_cnt == BIT_END) begin
						rx_bit <= rx_bit + 1'b1;
						if (rx_bit == 3'd7) begin
							rx_state <= SCI_RX_STOP;
						end
					end
				end
				SCI_RX_STOP: begin
					if (rx_cnt == BIT_END) begin
						rx_state <= SCI_RX_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (rx_state == SCI_RX_DATA && rx_cnt == BIT_END) begin
			rx_shift <= {rxd_s, rx_shift[7:1]};
		end
		if (rx_stop_ok) begin
			rx_data <= rx_shift;
		end
	end

	// Status, enables and the latched interrupt
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			rx_valid <= 1'b0;
			irq_en <= '0;
			irq <= 1'b0;
			bus.rvalid <= 1'b0;
		end else begin
			bus.rvalid <= rd;
			if (rx_stop_ok) begin
				rx_valid <= 1'b1;
			end else if (rd && bus.addr == SCI_DATA_IDX) begin
				rx_valid <= 1'b0;
			end
			if (wr && bus.addr == SCI_STAT_IDX) begin
				irq_en <= bus.wdata[1:0];
			end
			if ((rx_stop_ok && irq_en[0]) || (tx_finish && irq_en[1])) begin
				irq <= 1'b1;
			end else if (irq_ack) begin
				irq <= 1'b0;
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		case (bus.addr)
			SCI_DATA_IDX: bus.rdata <= {24'd0, rx_data};
			SCI_STAT_IDX: bus.rdata <= {30'd0, rx_valid, tx_busy};
			default: bus.rdata <= '0;
		endcase
	end

endmodule

// File: src/dps_irq.sv
// Two-source interrupt controller; only entries 0x36 and 0x37 exist, writes to other entries are dropped
`timescale 1ns/1ps

module dps_irq
	import dps_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic cfg_req,
	input dps_irq_num_t cfg_entry,
	input logic cfg_mask,
	input logic cfg_valid,
	input dps_irq_level_t cfg_level,
	input logic [1:0] src_irq,
	output logic [1:0] src_ack,
	output logic irq_req,
	output dps_irq_num_t irq_num,
	input logic irq_ack
);

	// Entry 0 is the timer, entry 1 the SCI
	logic [1:0] ent_valid;
	logic [1:0] ent_mask;
	dps_irq_level_t ent_level [2];
	logic [1:0] pend;
	logic pick_sci;
	logic sel_sci;

	assign pend = src_irq & ent_valid & ~ent_mask;
	// Higher level wins, timer takes ties
	assign pick_sci = pend[1] && (!pend[0] || ent_level[1] > ent_level[0]);
	assign irq_num = sel_sci ? IRQ_NUM_SCI : IRQ_NUM_UTIM64;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			ent_valid <= '0;
			ent_mask <= '0;
			ent_level[0] <= '0;
			ent_level[1] <= '0;
		end else if (cfg_req && cfg_entry == IRQ_NUM_UTIM64) begin
			ent_valid[0] <= cfg_valid;
			ent_mask[0] <= cfg_mask;
			ent_level[0] <= cfg_level;
		end else if (cfg_req && cfg_entry == IRQ_NUM_SCI) begin
			ent_valid[1] <= cfg_valid;
			ent_mask[1] <= cfg_mask;
			ent_level[1] <= cfg_level;
		end
	end

	// No new request while an ack pulse is out, the source flag clears after it
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			irq_req <= 1'b0;
			sel_sci <= 1'b0;
			src_ack <= '0;
		end else begin
			src_ack <= '0;
			if (irq_req) begin
				if (irq_ack) begin
					irq_req <= 1'b0;
					src_ack <= sel_sci ? 2'b10 : 2'b01;
				end
			end else if (src_ack == 2'b00 && pend != 2'b00) begin
				irq_req <= 1'b1;
				sel_sci <= pick_sci;
			end
		end
	end

	irq_num_stable: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(irq_req && !irq_ack) |=> (irq_req && $stable(irq_num)));

endmodule

// File: src/default_peripheral_system.sv
// Peripheral top on iCLOCK only; unmapped addresses are never accepted and writes get no response
`timescale 1ns/1ps

module default_peripheral_system
	import dps_pkg::*;
#(
	parameter int TIMER_DIV = 4,
	parameter int BAUD_DIV = 8
) (
	input logic iCLOCK,
	input logic inRESET,
	input logic dps_req,
	output logic dps_busy,
	input logic dps_rw,
	input dps_addr_t dps_addr,
	input dps_data_t dps_wdata,
	output logic dps_rvalid,
	output dps_data_t dps_rdata,
	input logic irq_cfg_req,
	input dps_irq_num_t irq_cfg_entry,
	input logic irq_cfg_mask,
	input logic irq_cfg_valid,
	input dps_irq_level_t irq_cfg_level,
	output logic irq_req,
	output dps_irq_num_t irq_num,
	input logic irq_ack,
	output logic sci_txd,
	input logic sci_rxd
);

	dps_req_if tim_bus ();
	dps_req_if sci_bus ();

	dps_stamp_e stamp_state;
	// Owner of the pending read, 1 for the SCI
	logic stamp_sci;
	logic free;
	logic tim_sel;
	logic sci_sel;
	logic [1:0] src_irq;
	logic [1:0] src_ack;

	assign free = (stamp_state == STAMP_IDLE) && !tim_bus.busy && !sci_bus.busy;
	assign tim_sel = dps_req && free && (dps_addr <= UTIM64_LAST_ADDR);
	assign sci_sel = dps_req && free &&
		((dps_addr == SCI_DATA_ADDR) || (dps_addr == SCI_STAT_ADDR));
	assign dps_busy = !free;

	assign tim_bus.req = tim_sel;
	assign tim_bus.rw = dps_rw;
	assign tim_bus.addr = dps_addr[6:2];
	assign tim_bus.wdata = dps_wdata;
	assign sci_bus.req = sci_sel;
	assign sci_bus.rw = dps_rw;
	assign sci_bus.addr = dps_addr[6:2];
	assign sci_bus.wdata = dps_wdata;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			stamp_state <= STAMP_IDLE;
			stamp_sci <= 1'b0;
		end else begin
			case (stamp_state)
				STAMP_IDLE: begin
					if (!dps_rw && (tim_sel || sci_sel)) begin
						stamp_state <= STAMP_READ_WAIT;
						stamp_sci <= sci_sel;
					end
				end
				STAMP_READ_WAIT: begin
					if (tim_bus.rvalid || sci_bus.rvalid) begin
						stamp_state <= STAMP_IDLE;
					end
				end
			endcase
		end
	end

	// Response comes back from the stamped owner
	assign dps_rvalid = stamp_sci ? sci_bus.rvalid : tim_bus.rvalid;
	assign dps_rdata = stamp_sci ? sci_bus.rdata : tim_bus.rdata;

	dps_utim64 #(.TIMER_DIV(TIMER_DIV)) u_utim64 (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.bus(tim_bus.device),
		.irq(src_irq[0]),
		.irq_ack(src_ack[0])
	);

	dps_sci #(.BAUD_DIV(BAUD_DIV)) u_sci (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.bus(sci_bus.device),
		.txd(sci_txd),
		.rxd(sci_rxd),
		.irq(src_irq[1]),
		.irq_ack(src_ack[1])
	);

	dps_irq u_irq (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.cfg_req(irq_cfg_req),
		.cfg_entry(irq_cfg_entry),
		.cfg_mask(irq_cfg_mask),
		.cfg_valid(irq_cfg_valid),
		.cfg_level(irq_cfg_level),
		.src_irq(src_irq),
		.src_ack(src_ack),
		.irq_req(irq_req),
		.irq_num(irq_num),
		.irq_ack(irq_ack)
	);

	sel_exclusive: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!(tim_sel && sci_sel));

endmodule

// File: bench/dps_clock_gen.sv
// Free-running testbench clock; reset is released a few ns after a rising edge, never on it
`timescale 1ns/1ps

module dps_clock_gen #(
	parameter int PERIOD_NS = 40,
	parameter int RESET_CYCLES = 4
) (
	output logic iCLOCK,
	output logic inRESET
);

	initial begin
		iCLOCK = 1'b0;
		forever begin
			#(PERIOD_NS / 2) iCLOCK = ~iCLOCK;
		end
	end

	initial begin
		inRESET = 1'b0;
		repeat (RESET_CYCLES) @(posedge iCLOCK);
		#2 inRESET = 1'b1;
	end

endmodule

// File: bench/tb_default_peripheral_system.sv
// Self-checking testbench; sci_txd is looped back to sci_rxd, so every byte sent is also received
`timescale 1ns/1ps

module tb_default_peripheral_system
	import dps_pkg::*;
();

	localparam int TIMER_DIV = 4;
	localparam int BAUD_DIV = 8;
	localparam int TAB_LEN = 12;
	localparam int LOOP_BYTES = 4;
	// Loopback bytes plus the two sent in the interrupt tests
	localparam int BYTE_COUNT = LOOP_BYTES + 2;
	localparam int CYCLE_LIMIT = TAB_LEN * 4 + BYTE_COUNT * 12 * BAUD_DIV + 2000;
	localparam logic [31:0] RAND_SEED = 32'haf54_4fc2;

	typedef struct packed {
		logic wr;
		dps_addr_t addr;
		dps_data_t wdata;
		dps_data_t rdata;
	} stim_t;

	// Timer registers: compare, period and control readback, then unused indices
	localparam stim_t STIM_TAB [TAB_LEN] = '{
		'{1'b1, 32'h0000_000C, 32'h89AB_CDEF, 32'h0000_0000},
		'{1'b1, 32'h0000_0010, 32'h0000_0012, 32'h0000_0000},
		'{1'b1, 32'h0000_0014, 32'h0000_0100, 32'h0000_0000},
		'{1'b1, 32'h0000_0000, 32'h0000_0006, 32'h0000_0000},
		'{1'b0, 32'h0000_000C, 32'h0000_0000, 32'h89AB_CDEF},
		'{1'b0, 32'h0000_0010, 32'h0000_0000, 32'h0000_0012},
		'{1'b0, 32'h0000_0014, 32'h0000_0000, 32'h0000_0100},
		'{1'b0, 32'h0000_0000, 32'h0000_0000, 32'h0000_0006},
		'{1'b0, 32'h0000_0018, 32'h0000_0000, 32'h0000_0000},
		'{1'b1, 32'h0000_0074, 32'hFFFF_FFFF, 32'h0000_0000},
		'{1'b0, 32'h0000_0074, 32'h0000_0000, 32'h0000_0000},
		'{1'b0, 32'h0000_0040, 32'h0000_0000, 32'h0000_0000}
	};

	logic iCLOCK;
	logic inRESET;
	logic dps_req;
	logic dps_busy;
	logic dps_rw;
	dps_addr_t dps_addr;
	dps_data_t dps_wdata;
	logic dps_rvalid;
	dps_data_t dps_rdata;
	logic irq_cfg_req;
	dps_irq_num_t irq_cfg_entry;
	logic irq_cfg_mask;
	logic irq_cfg_valid;
	dps_irq_level_t irq_cfg_level;
	logic irq_req;
	dps_irq_num_t irq_num;
	logic irq_ack;
	logic sci_txd;
	logic sci_rxd;
	int cycles = 0;

	assign sci_rxd = sci_txd;

	dps_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(4)) u_clock_gen (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET)
	);

	default_peripheral_system #(.TIMER_DIV(TIMER_DIV), .BAUD_DIV(BAUD_DIV)) u_dut (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.dps_req(dps_req),
		.dps_busy(dps_busy),
		.dps_rw(dps_rw),
		.dps_addr(dps_addr),
		.dps_wdata(dps_wdata),
		.dps_rvalid(dps_rvalid),
		.dps_rdata(dps_rdata),
		.irq_cfg_req(irq_cfg_req),
		.irq_cfg_entry(irq_cfg_entry),
		.irq_cfg_mask(irq_cfg_mask),
		.irq_cfg_valid(irq_cfg_valid),
		.irq_cfg_level(irq_cfg_level),
		.irq_req(irq_req),
		.irq_num(irq_num),
		.irq_ack(irq_ack),
		.sci_txd(sci_txd),
		.sci_rxd(sci_rxd)
	);

	always @(posedge iCLOCK) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles before all tests finished", cycles);
			$display("TEST FAIL");
			$fatal(1);
		end
	end

	task automatic check_value(input string name, input dps_data_t actual,
		input dps_data_t expected);
		if (actual !== expected) begin
			$display("Error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	// Request stays up until busy is seen low before a rising edge
	task automatic issue_req(input logic rw, input dps_addr_t addr, input dps_data_t wdata);
		@(posedge iCLOCK);
		#2;
		dps_req = 1'b1;
		dps_rw = rw;
		dps_addr = addr;
		dps_wdata = wdata;
		@(negedge iCLOCK);
		while (dps_busy) begin
			@(negedge iCLOCK);
		end
		@(posedge iCLOCK);
		#2;
		dps_req = 1'b0;
	endtask

	task automatic bus_write(input dps_addr_t addr, input dps_data_t wdata);
		issue_req(1'b1, addr, wdata);
	endtask

	// One rvalid pulse in the cycle after acceptance
	task automatic bus_read(input dps_addr_t addr, output dps_data_t rdata);
		issue_req(1'b0, addr, 32'd0);
		@(negedge iCLOCK);
		check_value("dps_rvalid", 32'(dps_rvalid), 32'd1);
		rdata = dps_rdata;
		@(negedge iCLOCK);
		check_value("dps_rvalid", 32'(dps_rvalid), 32'd0);
	endtask

	task automatic wait_rx_valid();
		dps_data_t status;
		status = '0;
		while (!status[1]) begin
			bus_read(SCI_STAT_ADDR, status);
		end
	endtask

	task automatic send_and_receive(input logic [7:0] value);
		dps_data_t rx;
		bus_write(SCI_DATA_ADDR, 32'(value));
		wait_rx_valid();
		bus_read(SCI_DATA_ADDR, rx);
		check_value("dps_rdata", rx, 32'(value));
	endtask

	task automatic set_irq_entry(input dps_irq_num_t entry, input logic valid,
		input logic mask, input dps_irq_level_t level);
		@(posedge iCLOCK);
		#2;
		irq_cfg_req = 1'b1;
		irq_cfg_entry = entry;
		irq_cfg_valid = valid;
		irq_cfg_mask = mask;
		irq_cfg_level = level;
		@(posedge iCLOCK);
		#2;
		irq_cfg_req = 1'b0;
	endtask

	// Compare a few ticks ahead of the running count
	task automatic arm_compare();
		dps_data_t now;
		bus_read(32'h0000_0004, now);
		bus_write(32'h0000_000C, now + 32'd8);
	endtask

	task automatic wait_irq(input dps_irq_num_t expected);
		@(negedge iCLOCK);
		while (!irq_req) begin
			@(negedge iCLOCK);
		end
		check_value("irq_num", 32'(irq_num), 32'(expected));
	endtask

	task automatic ack_irq();
		@(posedge iCLOCK);
		#2;
		irq_ack = 1'b1;
		@(posedge iCLOCK);
		#2;
		irq_ack = 1'b0;
	endtask

	initial begin
		dps_data_t rdata;
		dps_data_t first;
		dps_data_t second;
		logic [7:0] sent;
		dps_req = 1'b0;
		dps_rw = 1'b0;
		dps_addr = '0;
		dps_wdata = '0;
		irq_cfg_req = 1'b0;
		irq_cfg_entry = '0;
		irq_cfg_mask = 1'b0;
		irq_cfg_valid = 1'b0;
		irq_cfg_level = '0;
		irq_ack = 1'b0;
		void'($urandom(RAND_SEED));
		@(posedge inRESET);
		@(negedge iCLOCK);
		check_value("dps_busy", 32'(dps_busy), 32'd0);
		check_value("dps_rvalid", 32'(dps_rvalid), 32'd0);
		check_value("irq_req", 32'(irq_req), 32'd0);
		check_value("sci_txd", 32'(sci_txd), 32'd1);

		for (int i = 0; i < TAB_LEN; i++) begin
			if (STIM_TAB[i].wr) begin
				bus_write(STIM_TAB[i].addr, STIM_TAB[i].wdata);
			end else begin
				bus_read(STIM_TAB[i].addr, rdata);
				check_value("dps_rdata", rdata, STIM_TAB[i].rdata);
			end
		end

		// Unmapped address is held and never answered
		@(posedge iCLOCK);
		#2;
		dps_req = 1'b1;
		dps_rw = 1'b0;
		dps_addr = 32'h0000_0200;
		repeat (20) begin
			@(negedge iCLOCK);
			check_value("dps_rvalid", 32'(dps_rvalid), 32'd0);
		end
		@(posedge iCLOCK);
		#2;
		dps_req = 1'b0;
		bus_read(32'h0000_0014, rdata);
		check_value("dps_rdata", rdata, 32'h0000_0100);

		bus_write(32'h0000_0004, 32'd0);
		bus_write(32'h0000_0008, 32'd0);
		bus_write(32'h0000_0000, 32'h0000_0001);
		bus_read(32'h0000_0004, first);
		repeat (2 * TIMER_DIV) @(posedge iCLOCK);
		bus_read(32'h0000_0004, second);
		check_value("count low increase", 32'(second > first), 32'd1);

		for (int i = 0; i < LOOP_BYTES; i++) begin
			sent = 8'($urandom());
			send_and_receive(sent);
		end

		// Both sources pending at equal levels, timer first
		set_irq_entry(IRQ_NUM_UTIM64, 1'b1, 1'b0, 2'd2);
		set_irq_entry(IRQ_NUM_SCI, 1'b1, 1'b0, 2'd2);
		bus_write(SCI_STAT_ADDR, 32'h0000_0001);
		bus_write(32'h0000_0000, 32'h0000_0003);
		bus_write(32'h0000_0010, 32'd0);
		arm_compare();
		sent = 8'($urandom());
		bus_write(SCI_DATA_ADDR, 32'(sent));
		wait_irq(IRQ_NUM_UTIM64);
		wait_rx_valid();
		bus_read(SCI_DATA_ADDR, rdata);
		check_value("dps_rdata", rdata, 32'(sent));
		ack_irq();
		wait_irq(IRQ_NUM_SCI);
		ack_irq();

		// Timer entry masked, only the SCI gets through
		set_irq_entry(IRQ_NUM_UTIM64, 1'b1, 1'b1, 2'd2);
		arm_compare();
		sent = 8'($urandom());
		send_and_receive(sent);
		wait_irq(IRQ_NUM_SCI);
		ack_irq();
		repeat (20) begin
			@(negedge iCLOCK);
			check_value("irq_req", 32'(irq_req), 32'd0);
		end

		$display("TEST PASS");
		$finish;
	end

endmodule

// File: default_peripheral_system.f
src/dps_pkg.sv
src/dps_req_if.sv
src/dps_utim64.sv
src/dps_sci.sv
src/dps_irq.sv
src/default_peripheral_system.sv
bench/dps_clock_gen.sv
bench/tb_default_peripheral_system.sv

// File: Makefile
# Verilator build, run and lint for the peripheral subsystem

VERILATOR ?= verilator
TOP ?= tb_default_peripheral_system
RTL_TOP ?= default_peripheral_system
FLIST ?= default_peripheral_system.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= -Wall
PASS_TEXT ?= TEST PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The exit status comes from the search for the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
